/* sources.f */
verilog/ctrl_pkg.sv
verilog/ctrl_word_if.sv
verilog/instr_decoder.sv
verilog/state_sequencer.sv
verilog/control_outputs.sv
verilog/control_unit.sv
testbench/control_unit_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Wno-fatal
TOP       = control_unit_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/control_unit_tb.sv */
`timescale 1ns/1ps

module control_unit_tb;
	import ctrl_pkg::*;

	localparam int CLOCK_PERIOD  = 20;
	localparam int RESET_CYCLES  = 3;
	localparam int SEED          = 67636;
	localparam int MAX_ROWS      = 40;
	localparam int MARGIN_CYCLES = 40;

	typedef struct packed {
		logic [5:0] op_code;
		logic [5:0] funct;
		logic       equal;
		logic       greater;
		logic [3:0] wait_len;    // Cycles in the mult/div wait state
		logic [4:0] cycles;      // ir_write to ir_write
		logic [1:0] reg_writes;
		logic [1:0] mem_writes;
		logic [1:0] data_writes; // Memory data register latches
		logic [1:0] pc_writes;
		logic [1:0] hilo_writes;
		logic [1:0] starts;
		logic [1:0] alu_outs;    // Decode plus execute latches
		logic [2:0] alu_op;      // ALU op at the execute latch
		logic [1:0] reg_dst;
		logic [2:0] mem_to_reg;
		logic [1:0] pc_source;   // Source of the instruction's own pc_write
	} row_t;

	row_t rows [MAX_ROWS];
	int   row_count;
	int   error_count = 0;
	int   check_count = 0;
	bit   table_ready = 1'b0;

	logic       clock;
	logic       reset;
	logic [5:0] i_op_code;
	logic [5:0] i_funct;
	logic       i_equal;
	logic       i_greater;
	logic       i_mult_end;
	logic       i_div_end;

	logic       o_ir_write;
	logic       o_pc_write;
	logic [1:0] o_pc_source;
	logic [1:0] o_i_or_d;
	logic       o_memory_write;
	logic       o_mem_data_write;
	logic       o_reg_write;
	logic       o_a_b_write;
	logic [2:0] o_mem_to_reg;
	logic [1:0] o_reg_dst;
	logic [2:0] o_alu_op;
	logic       o_alu_src_a;
	logic [1:0] o_alu_src_b;
	logic       o_alu_out_write;
	logic       o_mult_start;
	logic       o_div_start;
	logic       o_div_or_mult;
	logic       o_high_write;
	logic       o_low_write;

	control_unit dut_i (
		.i_clock          (clock),
		.i_reset          (reset),
		.i_op_code        (i_op_code),
		.i_funct          (i_funct),
		.i_equal          (i_equal),
		.i_greater        (i_greater),
		.i_mult_end       (i_mult_end),
		.i_div_end        (i_div_end),
		.o_ir_write       (o_ir_write),
		.o_pc_write       (o_pc_write),
		.o_pc_source      (o_pc_source),
		.o_i_or_d         (o_i_or_d),
		.o_memory_write   (o_memory_write),
		.o_mem_data_write (o_mem_data_write),
		.o_reg_write      (o_reg_write),
		.o_a_b_write      (o_a_b_write),
		.o_mem_to_reg     (o_mem_to_reg),
		.o_reg_dst        (o_reg_dst),
		.o_alu_op         (o_alu_op),
		.o_alu_src_a      (o_alu_src_a),
		.o_alu_src_b      (o_alu_src_b),
		.o_alu_out_write  (o_alu_out_write),
		.o_mult_start     (o_mult_start),
		.o_div_start      (o_div_start),
		.o_div_or_mult    (o_div_or_mult),
		.o_high_write     (o_high_write),
		.o_low_write      (o_low_write)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	task automatic compare_value(input string what, input int expected, input int actual);
		check_count++;
		assert (actual == expected) else begin
			error_count++;
			$display("CHECK FAILED %s: expected 0x%0h, got 0x%0h", what, expected, actual);
		end
	endtask

	task automatic add_row(
		input logic [5:0] op_code,
		input logic [5:0] funct,
		input logic       equal,
		input logic       greater,
		input int         wait_len,
		input int         cycles,
		input int         reg_writes,
		input int         mem_writes,
		input int         data_writes,
		input int         pc_writes,
		input int         hilo_writes,
		input int         alu_outs,
		input logic [2:0] alu_op,
		input logic [1:0] reg_dst,
		input logic [2:0] mem_to_reg,
		input logic [1:0] pc_source
	);
		row_t row;
		row.op_code     = op_code;
		row.funct       = funct;
		row.equal       = equal;
		row.greater     = greater;
		row.wait_len    = 4'(wait_len);
		row.cycles      = 5'(cycles);
		row.reg_writes  = 2'(reg_writes);
		row.mem_writes  = 2'(mem_writes);
		row.data_writes = 2'(data_writes);
		row.pc_writes   = 2'(pc_writes);
		row.hilo_writes = 2'(hilo_writes);
		row.starts      = 2'(hilo_writes); // One start per hi/lo result
		row.alu_outs    = 2'(alu_outs);
		row.alu_op      = alu_op;
		row.reg_dst     = reg_dst;
		row.mem_to_reg  = mem_to_reg;
		row.pc_source   = pc_source;
		rows[row_count] = row;
		row_count++;
	endtask

	task automatic load_table();
		int   combo;
		int   wait_len;
		logic eq;
		logic gt;
		row_count = 0;
		add_row(OP_RTYPE, FN_ADD, 1'b0, 1'b0, 0, 8, 1, 0, 0, 1, 0,
			2, ALU_ADD, DST_RD, WB_ALU_OUT, PC_SRC_ALU);
		add_row(OP_RTYPE, FN_SUB, 1'b0, 1'b0, 0, 8, 1, 0, 0, 1, 0,
			2, ALU_SUB, DST_RD, WB_ALU_OUT, PC_SRC_ALU);
		add_row(OP_RTYPE, FN_AND, 1'b0, 1'b0, 0, 8, 1, 0, 0, 1, 0,
			2, ALU_AND, DST_RD, WB_ALU_OUT, PC_SRC_ALU);
		add_row(OP_RTYPE, FN_SLT, 1'b0, 1'b0, 0, 7, 1, 0, 0, 1, 0,
			1, ALU_ADD, DST_RD, WB_CMP, PC_SRC_ALU);
		add_row(OP_ADDI, 6'h00, 1'b0, 1'b0, 0, 8, 1, 0, 0, 1, 0,
			2, ALU_ADD, DST_RT, WB_ALU_OUT, PC_SRC_ALU);
		add_row(OP_ADDIU, 6'h15, 1'b0, 1'b0, 0, 8, 1, 0, 0, 1, 0,
			2, ALU_ADD, DST_RT, WB_ALU_OUT, PC_SRC_ALU);
		// Taken branch adds a second pc_write to the fetch one
		for (combo = 0; combo < 4; combo++) begin
			eq = combo[0];
			gt = combo[1];
			add_row(OP_BEQ, 6'h00, eq, gt, 0, 8, 0, 0, 0, eq ? 2 : 1, 0,
				1, ALU_ADD, DST_RT, WB_ALU_OUT, PC_SRC_ALU_OUT);
			add_row(OP_BNE, 6'h00, eq, gt, 0, 8, 0, 0, 0, eq ? 1 : 2, 0,
				1, ALU_ADD, DST_RT, WB_ALU_OUT, PC_SRC_ALU_OUT);
			add_row(OP_BGT, 6'h00, eq, gt, 0, 8, 0, 0, 0, gt ? 2 : 1, 0,
				1, ALU_ADD, DST_RT, WB_ALU_OUT, PC_SRC_ALU_OUT);
			add_row(OP_BLE, 6'h00, eq, gt, 0, 8, 0, 0, 0, gt ? 1 : 2, 0,
				1, ALU_ADD, DST_RT, WB_ALU_OUT, PC_SRC_ALU_OUT);
		end
		add_row(OP_LW, 6'h00, 1'b0, 1'b0, 0, 10, 1, 0, 1, 1, 0,
			2, ALU_ADD, DST_RT, WB_MEM, PC_SRC_ALU);
		add_row(OP_SW, 6'h00, 1'b0, 1'b0, 0, 10, 0, 1, 1, 1, 0,
			2, ALU_ADD, DST_RT, WB_ALU_OUT, PC_SRC_ALU);
		add_row(OP_J, 6'h00, 1'b0, 1'b0, 0, 7, 0, 0, 0, 2, 0,
			1, ALU_ADD, DST_RT, WB_ALU_OUT, PC_SRC_JUMP);
		add_row(OP_RTYPE, FN_JR, 1'b0, 1'b0, 0, 7, 0, 0, 0, 2, 0,
			1, ALU_ADD, DST_RT, WB_ALU_OUT, PC_SRC_ALU);
		add_row(OP_JAL, 6'h00, 1'b0, 1'b0, 0, 9, 1, 0, 0, 2, 0,
			2, ALU_LOAD, DST_RA, WB_ALU_OUT, PC_SRC_JUMP);
		add_row(6'b111111, 6'h00, 1'b0, 1'b0, 0, 6, 0, 0, 0, 1, 0,
			1, ALU_ADD, DST_RT, WB_ALU_OUT, PC_SRC_ALU); // Unknown opcode
		add_row(OP_RTYPE, 6'b111111, 1'b0, 1'b0, 0, 6, 0, 0, 0, 1, 0,
			1, ALU_ADD, DST_RT, WB_ALU_OUT, PC_SRC_ALU); // Unknown funct
		for (combo = 0; combo < 4; combo++) begin
			wait_len = 2 + int'($urandom % 8);
			add_row(OP_RTYPE, combo[0] ? FN_DIV : FN_MULT, 1'b0, 1'b0,
				wait_len, 7 + wait_len, 0, 0, 0, 1, 1,
				1, ALU_ADD, DST_RT, WB_ALU_OUT, PC_SRC_ALU);
		end
	endtask

	task automatic await_first_fetch();
		int pc_writes;
		bit seen_fetch;
		pc_writes = 0;
		seen_fetch = 1'b0;
		while (!seen_fetch) begin
			@(negedge clock);
			compare_value("before first fetch o_reg_write", 0, int'(o_reg_write));
			compare_value("before first fetch o_memory_write", 0, int'(o_memory_write));
			compare_value("before first fetch o_mem_data_write", 0, int'(o_mem_data_write));
			compare_value("before first fetch o_a_b_write", 0, int'(o_a_b_write));
			compare_value("before first fetch o_alu_out_write", 0, int'(o_alu_out_write));
			compare_value("before first fetch o_mult_start", 0, int'(o_mult_start));
			compare_value("before first fetch o_div_start", 0, int'(o_div_start));
			compare_value("before first fetch o_high_write", 0, int'(o_high_write));
			compare_value("before first fetch o_low_write", 0, int'(o_low_write));
			if (o_pc_write) begin
				pc_writes++;
			end
			seen_fetch = o_ir_write;
		end
		compare_value("before first fetch o_pc_write count", 1, pc_writes);
	endtask

	// Entered in the cycle where ir_write is high, ends at the next one
	task automatic run_row(input int index);
		row_t  row;
		string tag;
		int    cycles;
		int    reg_writes;
		int    mem_writes;
		int    data_writes;
		int    pc_writes;
		int    ab_writes;
		int    alu_outs;
		int    hilo_writes;
		int    high_writes;
		int    low_writes;
		int    mult_starts;
		int    div_starts;
		int    wait_cnt;
		bit    in_wait;
		bit    is_mult;
		bit    raise_end;
		bit    seen_fetch;
		row = rows[index];
		tag = $sformatf("row %0d", index);
		cycles = 0;
		reg_writes = 0;
		mem_writes = 0;
		data_writes = 0;
		pc_writes = 0;
		ab_writes = 0;
		alu_outs = 0;
		hilo_writes = 0;
		high_writes = 0;
		low_writes = 0;
		mult_starts = 0;
		div_starts = 0;
		wait_cnt = 0;
		in_wait = 1'b0;
		is_mult = (row.op_code == OP_RTYPE) && (row.funct == FN_MULT);
		seen_fetch = 1'b0;
		@(posedge clock);
		i_op_code <= row.op_code; // Decoded in DECODE_2, which starts now
		i_funct   <= row.funct;
		i_equal   <= row.equal;
		i_greater <= row.greater;
		while (!seen_fetch) begin
			@(negedge clock);
			cycles++;
			if (o_reg_write) begin
				reg_writes++;
				compare_value({tag, " o_reg_dst"}, int'(row.reg_dst), int'(o_reg_dst));
				compare_value({tag, " o_mem_to_reg"},
					int'(row.mem_to_reg), int'(o_mem_to_reg));
			end
			if (o_memory_write) begin
				mem_writes++;
				compare_value({tag, " o_i_or_d on store"}, 1, int'(o_i_or_d));
			end
			if (o_mem_data_write) begin
				data_writes++;
				compare_value({tag, " o_i_or_d on data read"}, 1, int'(o_i_or_d));
			end
			if (o_pc_write) begin
				pc_writes++;
				// Own jump or branch write comes before the next fetch increment
				compare_value({tag, " o_pc_source"},
					(pc_writes == 1 && row.pc_writes == 2) ?
						int'(row.pc_source) : int'(PC_SRC_ALU),
					int'(o_pc_source));
			end
			if (o_a_b_write) ab_writes++;
			if (o_alu_out_write) begin
				alu_outs++;
				compare_value({tag, " o_alu_op"},
					(alu_outs == 1) ? int'(ALU_ADD) : int'(row.alu_op), int'(o_alu_op));
				if (alu_outs == 1) begin
					compare_value({tag, " o_alu_src_b at decode"},
						int'(SRC_B_BRANCH_OFS), int'(o_alu_src_b));
				end
			end
			if (o_high_write) high_writes++;
			if (o_low_write) low_writes++;
			if (o_high_write && o_low_write) begin
				hilo_writes++;
				compare_value({tag, " o_div_or_mult"}, int'(is_mult), int'(o_div_or_mult));
			end
			if (o_mult_start) mult_starts++;
			if (o_div_start) div_starts++;
			if (o_mult_start || o_div_start) begin
				in_wait = 1'b1; // Start pulse shows in the first wait cycle
				wait_cnt = 0;
			end
			raise_end = 1'b0;
			if (in_wait) begin
				wait_cnt++;
				raise_end = (wait_cnt == int'(row.wait_len) - 1);
			end
			seen_fetch = o_ir_write;
			if (seen_fetch) begin
				// PC + 4 while the instruction is read from PC
				compare_value({tag, " o_i_or_d at fetch"}, 0, int'(o_i_or_d));
				compare_value({tag, " o_alu_op at fetch"}, int'(ALU_ADD), int'(o_alu_op));
				compare_value({tag, " o_alu_src_a at fetch"}, 0, int'(o_alu_src_a));
				compare_value({tag, " o_alu_src_b at fetch"},
					int'(SRC_B_FOUR), int'(o_alu_src_b));
			end else begin
				@(posedge clock);
				i_mult_end <= raise_end && is_mult;
				i_div_end  <= raise_end && !is_mult;
			end
		end
		compare_value({tag, " o_ir_write period"}, int'(row.cycles), cycles);
		compare_value({tag, " o_reg_write count"}, int'(row.reg_writes), reg_writes);
		compare_value({tag, " o_memory_write count"}, int'(row.mem_writes), mem_writes);
		compare_value({tag, " o_mem_data_write count"}, int'(row.data_writes), data_writes);
		compare_value({tag, " o_pc_write count"}, int'(row.pc_writes), pc_writes);
		compare_value({tag, " o_a_b_write count"}, 1, ab_writes);
		compare_value({tag, " o_alu_out_write count"}, int'(row.alu_outs), alu_outs);
		compare_value({tag, " o_high_write/o_low_write count"},
			int'(row.hilo_writes), hilo_writes);
		compare_value({tag, " o_high_write count"}, int'(row.hilo_writes), high_writes);
		compare_value({tag, " o_low_write count"}, int'(row.hilo_writes), low_writes);
		compare_value({tag, " o_mult_start count"},
			is_mult ? int'(row.starts) : 0, mult_starts);
		compare_value({tag, " o_div_start count"},
			is_mult ? 0 : int'(row.starts), div_starts);
	endtask

	initial begin
		int index;
		clock      = 1'b0;
		reset      = 1'b1;
		i_op_code  = OP_RTYPE;
		i_funct    = FN_ADD;
		i_equal    = 1'b0;
		i_greater  = 1'b0;
		i_mult_end = 1'b0;
		i_div_end  = 1'b0;
		void'($urandom(SEED));
		load_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		await_first_fetch();
		for (index = 0; index < row_count; index++) begin
			run_row(index);
		end
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Run length is the table's total plus reset, first fetch and slack
	initial begin
		int limit_cycles;
		int k;
		wait (table_ready);
		limit_cycles = RESET_CYCLES + 10 + MARGIN_CYCLES;
		for (k = 0; k < row_count; k++) begin
			limit_cycles += int'(rows[k].cycles);
		end
		#(limit_cycles * CLOCK_PERIOD);
		$display("Watchdog expired after %0d cycles, the DUT stopped fetching", limit_cycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* verilog/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic [5:0]              i_op_code,
	input  logic [5:0]              i_funct,
	input  logic                    i_equal,
	input  logic                    i_greater,
	input  logic                    i_mult_end,
	input  logic                    i_div_end,
	output logic                    o_ir_write,
	output logic                    o_pc_write,
	output ctrl_pkg::pc_source_e    o_pc_source,
	output logic [1:0]              o_i_or_d,
	output logic                    o_memory_write,
	output logic                    o_mem_data_write,
	output logic                    o_reg_write,
	output logic                    o_a_b_write,
	output ctrl_pkg::mem_to_reg_e   o_mem_to_reg,
	output ctrl_pkg::reg_dst_e      o_reg_dst,
	output ctrl_pkg::alu_op_e       o_alu_op,
	output logic                    o_alu_src_a,
	output ctrl_pkg::alu_src_b_e    o_alu_src_b,
	output logic                    o_alu_out_write,
	output logic                    o_mult_start,
	output logic                    o_div_start,
	output logic                    o_div_or_mult,
	output logic                    o_high_write,
	output logic                    o_low_write
);

	ctrl_pkg::instr_class_e w_class;
	ctrl_pkg::cu_state_e    w_state;
	logic                   w_branch_taken;

	ctrl_word_if ctrl_word ();

	instr_decoder instr_decoder_i (
		.i_op_code (i_op_code),
		.i_funct   (i_funct),
		.o_class   (w_class)
	);

	state_sequencer state_sequencer_i (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_class        (w_class),
		.i_equal        (i_equal),
		.i_greater      (i_greater),
		.i_mult_end     (i_mult_end),
		.i_div_end      (i_div_end),
		.o_state        (w_state),
		.o_branch_taken (w_branch_taken)
	);

	control_outputs control_outputs_i (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_state        (w_state),
		.i_class        (w_class),
		.i_branch_taken (w_branch_taken),
		.ctrl           (ctrl_word.driver)
	);

	assign o_ir_write       = ctrl_word.ir_write;
	assign o_pc_write       = ctrl_word.pc_write;
	assign o_pc_source      = ctrl_word.pc_source;
	assign o_i_or_d         = ctrl_word.i_or_d;
	assign o_memory_write   = ctrl_word.memory_write;
	assign o_mem_data_write = ctrl_word.mem_data_write;
	assign o_reg_write      = ctrl_word.reg_write;
	assign o_a_b_write      = ctrl_word.a_b_write;
	assign o_mem_to_reg     = ctrl_word.mem_to_reg;
	assign o_reg_dst        = ctrl_word.reg_dst;
	assign o_alu_op         = ctrl_word.alu_op;
	assign o_alu_src_a      = ctrl_word.alu_src_a;
	assign o_alu_src_b      = ctrl_word.alu_src_b;
	assign o_alu_out_write  = ctrl_word.alu_out_write;
	assign o_mult_start     = ctrl_word.mult_start;
	assign o_div_start      = ctrl_word.div_start;
	assign o_div_or_mult    = ctrl_word.div_or_mult;
	assign o_high_write     = ctrl_word.high_write;
	assign o_low_write      = ctrl_word.low_write;

endmodule

/* verilog/control_outputs.sv */
`timescale 1ns/1ps

module control_outputs (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  ctrl_pkg::cu_state_e     i_state,
	input  ctrl_pkg::instr_class_e  i_class,
	input  logic                    i_branch_taken,
	ctrl_word_if.driver             ctrl
);
	import ctrl_pkg::*;

	cu_state_e prev_state;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			prev_state <= FETCH_1;
		end else begin
			prev_state <= i_state;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			ctrl.ir_write       <= 1'b0;
			ctrl.pc_write       <= 1'b0;
			ctrl.pc_source      <= PC_SRC_ALU;
			ctrl.i_or_d         <= 2'd0;
			ctrl.memory_write   <= 1'b0;
			ctrl.mem_data_write <= 1'b0;
			ctrl.reg_write      <= 1'b0;
			ctrl.a_b_write      <= 1'b0;
			ctrl.mem_to_reg     <= WB_ALU_OUT;
			ctrl.reg_dst        <= DST_RT;
			ctrl.alu_op         <= ALU_LOAD;
			ctrl.alu_src_a      <= 1'b0;
			ctrl.alu_src_b      <= SRC_B_REG;
			ctrl.alu_out_write  <= 1'b0;
			ctrl.mult_start     <= 1'b0;
			ctrl.div_start      <= 1'b0;
			ctrl.div_or_mult    <= 1'b0;
			ctrl.high_write     <= 1'b0;
			ctrl.low_write      <= 1'b0;
		end else begin
			ctrl.ir_write       <= 1'b0;
			ctrl.pc_write       <= 1'b0;
			ctrl.pc_source      <= PC_SRC_ALU;
			ctrl.i_or_d         <= 2'd0;
			ctrl.memory_write   <= 1'b0;
			ctrl.mem_data_write <= 1'b0;
			ctrl.reg_write      <= 1'b0;
			ctrl.a_b_write      <= 1'b0;
			ctrl.mem_to_reg     <= WB_ALU_OUT;
			ctrl.reg_dst        <= DST_RT;
			ctrl.alu_op         <= ALU_LOAD;
			ctrl.alu_src_a      <= 1'b0;
			ctrl.alu_src_b      <= SRC_B_REG;
			ctrl.alu_out_write  <= 1'b0;
			ctrl.mult_start     <= 1'b0;
			ctrl.div_start      <= 1'b0;
			ctrl.div_or_mult    <= 1'b0;
			ctrl.high_write     <= 1'b0;
			ctrl.low_write      <= 1'b0;

			case (i_state)
				FETCH_1, FETCH_2, FETCH_3: begin
					ctrl.alu_op    <= ALU_ADD; // PC + 4
					ctrl.alu_src_b <= SRC_B_FOUR;
					ctrl.pc_write  <= (i_state == FETCH_2);
					ctrl.ir_write  <= (i_state == FETCH_3);
				end
				DECODE_1: begin
					ctrl.alu_op        <= ALU_ADD; // Branch target ahead of time
					ctrl.alu_src_b     <= SRC_B_BRANCH_OFS;
					ctrl.a_b_write     <= 1'b1;
					ctrl.alu_out_write <= 1'b1;
				end
				DECODE_2: begin
					ctrl.alu_op <= ALU_ADD;
				end
				RTYPE_EXEC: begin
					case (i_class)
						CLS_SUB: ctrl.alu_op <= ALU_SUB;
						CLS_AND: ctrl.alu_op <= ALU_AND;
						default: ctrl.alu_op <= ALU_ADD;
					endcase
					ctrl.alu_src_a     <= 1'b1;
					ctrl.alu_out_write <= 1'b1;
				end
				RTYPE_WB: begin
					ctrl.reg_write <= 1'b1;
					ctrl.reg_dst   <= DST_RD;
				end
				SLT_WB: begin
					ctrl.alu_op     <= ALU_CMP;
					ctrl.alu_src_a  <= 1'b1;
					ctrl.reg_write  <= 1'b1;
					ctrl.reg_dst    <= DST_RD;
					ctrl.mem_to_reg <= WB_CMP; // Less-than flag into rd
				end
				ADDI_EXEC: begin
					ctrl.alu_op        <= ALU_ADD;
					ctrl.alu_src_a     <= 1'b1;
					ctrl.alu_src_b     <= SRC_B_IMM;
					ctrl.alu_out_write <= 1'b1;
				end
				ADDI_WB: begin
					ctrl.reg_write <= 1'b1;
					ctrl.reg_dst   <= DST_RT;
				end
				BRANCH_EQ_1, BRANCH_EQ_2, BRANCH_GT_1, BRANCH_GT_2: begin
					ctrl.alu_op    <= ALU_CMP;
					ctrl.alu_src_a <= 1'b1;
					ctrl.pc_source <= PC_SRC_ALU_OUT; // Target from decode
					ctrl.pc_write  <= i_branch_taken;
				end
				MEM_ADDR: begin
					ctrl.alu_op        <= ALU_ADD; // Base plus offset
					ctrl.alu_src_a     <= 1'b1;
					ctrl.alu_src_b     <= SRC_B_IMM;
					ctrl.alu_out_write <= 1'b1;
					ctrl.i_or_d        <= 2'd1;
				end
				MEM_WAIT, MEM_DATA: begin
					ctrl.alu_op         <= ALU_ADD;
					ctrl.alu_src_a      <= 1'b1;
					ctrl.alu_src_b      <= SRC_B_IMM;
					ctrl.i_or_d         <= 2'd1;
					ctrl.mem_data_write <= (i_state == MEM_DATA);
				end
				LOAD_WB: begin
					ctrl.i_or_d     <= 2'd1;
					ctrl.reg_write  <= 1'b1;
					ctrl.mem_to_reg <= WB_MEM;
				end
				STORE_WR: begin
					ctrl.i_or_d       <= 2'd1;
					ctrl.memory_write <= 1'b1;
				end
				JAL_LINK_1: begin
					ctrl.alu_out_write <= 1'b1; // Latch return address
				end
				JAL_LINK_2: begin
					ctrl.reg_write <= 1'b1;
					ctrl.reg_dst   <= DST_RA;
				end
				JUMP: begin
					ctrl.pc_write  <= 1'b1;
					ctrl.pc_source <= PC_SRC_JUMP;
				end
				JUMP_REG: begin
					ctrl.pc_write  <= 1'b1;
					ctrl.alu_src_a <= 1'b1; // rs straight through the ALU
				end
				MULT_START, MULT_WAIT: begin
					ctrl.mult_start  <= (i_state == MULT_START);
					ctrl.div_or_mult <= 1'b1;
				end
				DIV_START, DIV_WAIT: begin
					ctrl.div_start <= (i_state == DIV_START);
				end
				CLOSE_WRITE: begin
					// Arriving from a wait state means the unit just finished
					ctrl.high_write  <= (prev_state == MULT_WAIT) || (prev_state == DIV_WAIT);
					ctrl.low_write   <= (prev_state == MULT_WAIT) || (prev_state == DIV_WAIT);
					ctrl.div_or_mult <= (prev_state == MULT_WAIT);
				end
			endcase
		end
	end

endmodule

/* verilog/state_sequencer.sv */
`timescale 1ns/1ps

module state_sequencer (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  ctrl_pkg::instr_class_e  i_class,
	input  logic                    i_equal,
	input  logic                    i_greater,
	input  logic                    i_mult_end,
	input  logic                    i_div_end,
	output ctrl_pkg::cu_state_e     o_state,
	output logic                    o_branch_taken
);
	import ctrl_pkg::*;

	cu_state_e state;
	cu_state_e state_next;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= FETCH_1;
		end else begin
			state <= state_next;
		end
	end

	assign o_state = state;

	always_comb begin
		state_next = CLOSE_WRITE;
		case (state)
			FETCH_1:     state_next = FETCH_2;
			FETCH_2:     state_next = FETCH_3;
			FETCH_3:     state_next = DECODE_1;
			DECODE_1:    state_next = DECODE_2;
			DECODE_2: begin
				case (i_class)
					CLS_ADD, CLS_SUB, CLS_AND: state_next = RTYPE_EXEC;
					CLS_SLT:                   state_next = SLT_WB;
					CLS_ADDI:                  state_next = ADDI_EXEC;
					CLS_BEQ, CLS_BNE:          state_next = BRANCH_EQ_1;
					CLS_BLE, CLS_BGT:          state_next = BRANCH_GT_1;
					CLS_LW, CLS_SW:            state_next = MEM_ADDR;
					CLS_J:                     state_next = JUMP;
					CLS_JAL:                   state_next = JAL_LINK_1;
					CLS_JR:                    state_next = JUMP_REG;
					CLS_MULT:                  state_next = MULT_START;
					CLS_DIV:                   state_next = DIV_START;
					default:                   state_next = CLOSE_WRITE; // Unknown op
				endcase
			end
			RTYPE_EXEC:  state_next = RTYPE_WB;
			ADDI_EXEC:   state_next = ADDI_WB;
			BRANCH_EQ_1: state_next = BRANCH_EQ_2;
			BRANCH_GT_1: state_next = BRANCH_GT_2;
			MEM_ADDR:    state_next = MEM_WAIT;
			MEM_WAIT:    state_next = MEM_DATA;
			MEM_DATA:    state_next = (i_class == CLS_LW) ? LOAD_WB : STORE_WR;
			JAL_LINK_1:  state_next = JAL_LINK_2;
			JAL_LINK_2:  state_next = JUMP;
			MULT_START:  state_next = MULT_WAIT;
			MULT_WAIT:   state_next = i_mult_end ? CLOSE_WRITE : MULT_WAIT;
			DIV_START:   state_next = DIV_WAIT;
			DIV_WAIT:    state_next = i_div_end ? CLOSE_WRITE : DIV_WAIT;
			CLOSE_WRITE: state_next = FETCH_1;
			default:     state_next = CLOSE_WRITE; // Single-step states close here
		endcase
	end

	// Flags are only looked at in the second branch state
	always_comb begin
		o_branch_taken = 1'b0;
		if (state == BRANCH_EQ_2 || state == BRANCH_GT_2) begin
			case (i_class)
				CLS_BEQ: o_branch_taken = i_equal;
				CLS_BNE: o_branch_taken = ~i_equal;
				CLS_BGT: o_branch_taken = i_greater;
				CLS_BLE: o_branch_taken = ~i_greater;
				default: o_branch_taken = 1'b0;
			endcase
		end
	end

endmodule

/* verilog/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input  logic [5:0]              i_op_code,
	input  logic [5:0]              i_funct,
	output ctrl_pkg::instr_class_e  o_class
);
	import ctrl_pkg::*;

	always_comb begin
		o_class = CLS_NONE;
		case (i_op_code)
			OP_RTYPE: begin
				case (i_funct) // Funct only matters here
					FN_ADD:  o_class = CLS_ADD;
					FN_SUB:  o_class = CLS_SUB;
					FN_AND:  o_class = CLS_AND;
					FN_SLT:  o_class = CLS_SLT;
					FN_JR:   o_class = CLS_JR;
					FN_MULT: o_class = CLS_MULT;
					FN_DIV:  o_class = CLS_DIV;
					default: o_class = CLS_NONE;
				endcase
			end
			OP_ADDI, OP_ADDIU: begin
				o_class = CLS_ADDI; // Same datapath use
			end
			OP_BEQ: begin
				o_class = CLS_BEQ;
			end
			OP_BNE: begin
				o_class = CLS_BNE;
			end
			OP_BLE: begin
				o_class = CLS_BLE;
			end
			OP_BGT: begin
				o_class = CLS_BGT;
			end
			OP_LW: begin
				o_class = CLS_LW;
			end
			OP_SW: begin
				o_class = CLS_SW;
			end
			OP_J: begin
				o_class = CLS_J;
			end
			OP_JAL: begin
				o_class = CLS_JAL;
			end
			default: begin
				o_class = CLS_NONE;
			end
		endcase
	end

endmodule

/* verilog/ctrl_word_if.sv */
`timescale 1ns/1ps

interface ctrl_word_if;
	import ctrl_pkg::*;

	logic        ir_write;
	logic        pc_write;
	pc_source_e  pc_source;
	logic [1:0]  i_or_d; // 0 selects PC, 1 selects ALU out
	logic        memory_write;
	logic        mem_data_write;

	logic        reg_write;
	logic        a_b_write;
	mem_to_reg_e mem_to_reg;
	reg_dst_e    reg_dst;

	alu_op_e     alu_op;
	logic        alu_src_a; // 1 selects register A
	alu_src_b_e  alu_src_b;
	logic        alu_out_write;

	logic        mult_start;
	logic        div_start;
	logic        div_or_mult; // 1 selects multiplier result
	logic        high_write;
	logic        low_write;

	modport driver (
		output ir_write, pc_write, pc_source, i_or_d, memory_write, mem_data_write,
		output reg_write, a_b_write, mem_to_reg, reg_dst,
		output alu_op, alu_src_a, alu_src_b, alu_out_write,
		output mult_start, div_start, div_or_mult, high_write, low_write
	);

	modport monitor (
		input ir_write, pc_write, pc_source, i_or_d, memory_write, mem_data_write,
		input reg_write, a_b_write, mem_to_reg, reg_dst,
		input alu_op, alu_src_a, alu_src_b, alu_out_write,
		input mult_start, div_start, div_or_mult, high_write, low_write
	);

endinterface

/* verilog/ctrl_pkg.sv */
package ctrl_pkg;

	typedef enum logic [5:0] {
		FETCH_1,
		FETCH_2,
		FETCH_3,
		DECODE_1,
		DECODE_2,
		RTYPE_EXEC,
		RTYPE_WB,
		SLT_WB,
		ADDI_EXEC,
		ADDI_WB,
		BRANCH_EQ_1,
		BRANCH_EQ_2,
		BRANCH_GT_1,
		BRANCH_GT_2,
		MEM_ADDR,
		MEM_WAIT,
		MEM_DATA,
		LOAD_WB,
		STORE_WR,
		JAL_LINK_1,
		JAL_LINK_2,
		JUMP,
		JUMP_REG,
		MULT_START,
		MULT_WAIT,
		DIV_START,
		DIV_WAIT,
		CLOSE_WRITE
	} cu_state_e;

	typedef enum logic [4:0] {
		CLS_ADD, CLS_SUB, CLS_AND, CLS_SLT, CLS_ADDI,
		CLS_BEQ, CLS_BNE, CLS_BLE, CLS_BGT,
		CLS_LW, CLS_SW, CLS_J, CLS_JAL, CLS_JR,
		CLS_MULT, CLS_DIV, CLS_NONE
	} instr_class_e;

	typedef enum logic [2:0] {
		ALU_LOAD = 3'b000, // Pass A through
		ALU_ADD  = 3'b001,
		ALU_SUB  = 3'b010,
		ALU_AND  = 3'b011,
		ALU_CMP  = 3'b111  // Equal, greater and less flags
	} alu_op_e;

	typedef enum logic [1:0] {
		PC_SRC_ALU     = 2'b00,
		PC_SRC_ALU_OUT = 2'b01,
		PC_SRC_JUMP    = 2'b10
	} pc_source_e;

	typedef enum logic [2:0] {
		WB_ALU_OUT = 3'b000,
		WB_MEM     = 3'b001,
		WB_CMP     = 3'b100,
		WB_SP_INIT = 3'b111
	} mem_to_reg_e;

	typedef enum logic [1:0] {
		DST_RT = 2'b00,
		DST_RA = 2'b01,
		DST_RD = 2'b11
	} reg_dst_e;

	typedef enum logic [1:0] {
		SRC_B_REG        = 2'b00,
		SRC_B_FOUR       = 2'b01,
		SRC_B_IMM        = 2'b10,
		SRC_B_BRANCH_OFS = 2'b11 // Shifted immediate
	} alu_src_b_e;

	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_BEQ   = 6'b000100;
	localparam logic [5:0] OP_BNE   = 6'b000101;
	localparam logic [5:0] OP_BLE   = 6'b000110;
	localparam logic [5:0] OP_BGT   = 6'b000111;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SW    = 6'b101011;
	localparam logic [5:0] OP_J     = 6'b000010;
	localparam logic [5:0] OP_JAL   = 6'b000011;

	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_MULT = 6'b011000;
	localparam logic [5:0] FN_DIV  = 6'b011010;

endpackage
